// File: compile.f
rtl/rv_pkg.sv
rtl/regfile.sv
rtl/id_stage.sv
rtl/exe_stage.sv
rtl/core_ctrl.sv
rtl/rvcore_top.sv
verif/tb_mem.sv
verif/rvcore_assert.sv
verif/tb_rvcore.sv

// File: rtl/core_ctrl.sv
// control fsm, pc and instruction registers, wishbone master and byte load alignment.
`timescale 1ns/10ps

module core_ctrl #(
  parameter logic [rv_pkg::XLEN-1:0] BOOT_ADDR = rv_pkg::DEF_BOOT_ADDR,
  parameter int                      WB_AW     = rv_pkg::DEF_WB_AW
) (
  input  logic                    clk,
  input  logic                    rst,
  // wishbone classic master.
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output logic [WB_AW-1:0]        wb_adr_o,
  output logic [3:0]              wb_sel_o,
  input  logic [31:0]             wb_dat_i,
  input  logic                    wb_ack_i,
  // decode and execute side.
  output logic [31:0]             inst_o,
  output logic [rv_pkg::XLEN-1:0] pc_o,
  input  rv_pkg::exe_res_s        res_i,
  // register file write port.
  output logic                    rf_we_o,
  output logic [4:0]              rf_wa_o,
  output logic [rv_pkg::XLEN-1:0] rf_wdata_o,
  // retire trace.
  output logic                    commit_valid_o,
  output rv_pkg::commit_s         commit_o
);

  rv_pkg::ctrl_state_e     state_q;
  rv_pkg::ctrl_state_e     state_d;
  logic [rv_pkg::XLEN-1:0] pc_q;
  logic [rv_pkg::XLEN-1:0] pc_next;
  logic [31:0]             ir_q;
  rv_pkg::exe_res_s        res_q;
  logic                    req_q;
  logic                    bus_done;
  logic [rv_pkg::XLEN-1:0] bus_addr;
  logic [7:0]              ld_byte;

  assign bus_done = req_q && wb_ack_i;

  // ----------------------------------------------------------
  // state machine
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      rv_pkg::FETCH:     if (bus_done) state_d = rv_pkg::DECODE;
      rv_pkg::DECODE:    state_d = rv_pkg::EXECUTE;
      rv_pkg::EXECUTE:   state_d = res_i.ld ? rv_pkg::MEMORY : rv_pkg::WRITEBACK;
      rv_pkg::MEMORY:    if (bus_done) state_d = rv_pkg::WRITEBACK;
      rv_pkg::WRITEBACK: state_d = rv_pkg::FETCH;
      default:           state_d = rv_pkg::FETCH;
    endcase
  end

  assign pc_next = res_q.jmp ? res_q.jmp_addr : pc_q + rv_pkg::PC_STEP;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= rv_pkg::FETCH;
      req_q   <= 1'b0;
      pc_q    <= BOOT_ADDR;
    end else begin
      state_q <= state_d;
      // request is held for as long as the next state needs the bus.
      req_q   <= (state_d == rv_pkg::FETCH) || (state_d == rv_pkg::MEMORY);
      if (state_q == rv_pkg::WRITEBACK) begin
        pc_q <= pc_next;
      end
    end
  end

  // ----------------------------------------------------------
  // instruction and result registers
  // ----------------------------------------------------------
  always_comb begin
    case (res_q.ld_addr[1:0])  // little endian lanes.
      2'd0:    ld_byte = wb_dat_i[7:0];
      2'd1:    ld_byte = wb_dat_i[15:8];
      2'd2:    ld_byte = wb_dat_i[23:16];
      default: ld_byte = wb_dat_i[31:24];
    endcase
  end

  always_ff @(posedge clk) begin
    if ((state_q == rv_pkg::FETCH) && bus_done) begin
      ir_q <= wb_dat_i;
    end
    if (state_q == rv_pkg::EXECUTE) begin
      res_q <= res_i;
    end else if ((state_q == rv_pkg::MEMORY) && bus_done) begin
      res_q.rd_wdata <= {{(rv_pkg::XLEN-8){ld_byte[7]}}, ld_byte};
    end
  end

  assign inst_o = ir_q;
  assign pc_o   = pc_q;

  // ----------------------------------------------------------
  // wishbone master
  // ----------------------------------------------------------
  assign bus_addr = (state_q == rv_pkg::MEMORY) ? res_q.ld_addr : pc_q;

  assign wb_cyc_o = req_q;
  assign wb_stb_o = req_q;
  assign wb_we_o  = 1'b0;                              // read only port.
  assign wb_adr_o = {bus_addr[WB_AW-1:2], 2'b00};
  assign wb_sel_o = (state_q == rv_pkg::MEMORY) ? (4'b0001 << res_q.ld_addr[1:0]) : 4'b1111;

  // ----------------------------------------------------------
  // writeback and commit
  // ----------------------------------------------------------
  assign rf_we_o    = (state_q == rv_pkg::WRITEBACK) && res_q.rd_we;
  assign rf_wa_o    = res_q.rd;
  assign rf_wdata_o = res_q.rd_wdata;

  assign commit_valid_o = (state_q == rv_pkg::WRITEBACK);

  always_comb begin
    commit_o.pc       = pc_q;
    commit_o.rd_we    = res_q.rd_we;
    commit_o.rd       = res_q.rd;
    commit_o.rd_wdata = res_q.rd_wdata;
  end

endmodule

// File: rtl/exe_stage.sv
// execute block: write data, branch decision, jump target and load address.
`timescale 1ns/10ps

module exe_stage (
  input  rv_pkg::dec_s     dec_i,
  output rv_pkg::exe_res_s res_o
);

  logic [rv_pkg::XLEN-1:0] sum;
  logic                    eq;
  logic                    lt_s;
  logic                    lt_u;
  logic [rv_pkg::XLEN-1:0] rd_data;
  logic                    jmp;
  logic [rv_pkg::XLEN-1:0] jmp_addr;

  // one adder serves auipc, addi, jalr and the load address.
  assign sum  = dec_i.op1 + dec_i.op2;
  assign eq   = (dec_i.op1 == dec_i.op2);
  assign lt_s = ($signed(dec_i.op1) < $signed(dec_i.op2));
  assign lt_u = (dec_i.op1 < dec_i.op2);

  // ----------------------------------------------------------
  // rd write data
  // ----------------------------------------------------------
  always_comb begin
    rd_data = '0;
    case (dec_i.opcode)
      rv_pkg::OPC_AUIPC: rd_data = sum;
      rv_pkg::OPC_ADDI: begin
        case (dec_i.funct3)
          rv_pkg::F3_ADDI:  rd_data = sum;
          rv_pkg::F3_SLTI:  rd_data = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
          rv_pkg::F3_SLTIU: rd_data = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
          default: ;
        endcase
      end
      rv_pkg::OPC_JAL:  rd_data = dec_i.op1;
      rv_pkg::OPC_JALR: rd_data = dec_i.t1;
      default: ;  // lb data is filled in by the memory access.
    endcase
  end

  // ----------------------------------------------------------
  // control transfer
  // ----------------------------------------------------------
  always_comb begin
    jmp      = 1'b0;
    jmp_addr = '0;
    case (dec_i.opcode)
      rv_pkg::OPC_JAL: begin
        jmp      = 1'b1;
        jmp_addr = dec_i.op2;
      end
      rv_pkg::OPC_JALR: begin
        jmp      = 1'b1;
        jmp_addr = {sum[rv_pkg::XLEN-1:1], 1'b0};
      end
      rv_pkg::OPC_BRANCH: begin
        jmp_addr = dec_i.t1;
        case (dec_i.funct3)
          rv_pkg::F3_BEQ:  jmp = eq;
          rv_pkg::F3_BNE:  jmp = !eq;
          rv_pkg::F3_BLT:  jmp = lt_s;
          rv_pkg::F3_BGE:  jmp = !lt_s;
          rv_pkg::F3_BLTU: jmp = lt_u;
          rv_pkg::F3_BGEU: jmp = !lt_u;
          default:         jmp = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

  always_comb begin
    res_o.rd_we    = dec_i.rd_we;
    res_o.rd       = dec_i.rd;
    res_o.rd_wdata = rd_data;
    res_o.jmp      = jmp;
    res_o.jmp_addr = jmp_addr;
    res_o.ld       = (dec_i.opcode == rv_pkg::OPC_LB) && (dec_i.funct3 == rv_pkg::F3_LB);
    res_o.ld_addr  = sum;
  end

endmodule

// File: rtl/id_stage.sv
// instruction decoder: field extraction, immediates and operand selection.
`timescale 1ns/10ps

module id_stage (
  input  logic [31:0]             inst_i,
  input  logic [rv_pkg::XLEN-1:0] pc_i,
  output logic [4:0]              ra_o,
  output logic [4:0]              rb_o,
  input  logic [rv_pkg::XLEN-1:0] rdata_a_i,
  input  logic [rv_pkg::XLEN-1:0] rdata_b_i,
  output rv_pkg::dec_s            dec_o
);

  rv_pkg::opcode_e         opcode;
  rv_pkg::funct3_e         funct3;
  logic [4:0]              rd;
  logic [rv_pkg::XLEN-1:0] imm_i;
  logic [rv_pkg::XLEN-1:0] imm_u;
  logic [rv_pkg::XLEN-1:0] imm_b;
  logic [rv_pkg::XLEN-1:0] imm_j;
  logic [rv_pkg::XLEN-1:0] pc_plus4;

  assign opcode = rv_pkg::opcode_e'(inst_i[6:2]);
  assign funct3 = inst_i[14:12];
  assign rd     = inst_i[11:7];
  assign ra_o   = inst_i[19:15];
  assign rb_o   = inst_i[24:20];

  // ----------------------------------------------------------
  // immediates, all sign extended from bit 31
  // ----------------------------------------------------------
  assign imm_i = {{(rv_pkg::XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {{(rv_pkg::XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_b = {{(rv_pkg::XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                  inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j = {{(rv_pkg::XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                  inst_i[20], inst_i[30:21], 1'b0};

  assign pc_plus4 = pc_i + rv_pkg::PC_STEP;

  // ----------------------------------------------------------
  // operand selection
  // ----------------------------------------------------------
  always_comb begin
    dec_o.opcode = opcode;
    dec_o.funct3 = funct3;
    dec_o.rd     = rd;
    dec_o.op1    = '0;
    dec_o.op2    = '0;
    dec_o.t1     = '0;
    dec_o.rd_we  = 1'b0;
    case (opcode)
      rv_pkg::OPC_AUIPC: begin
        dec_o.op1   = pc_i;
        dec_o.op2   = imm_u;
        dec_o.rd_we = 1'b1;
      end
      rv_pkg::OPC_ADDI: begin
        dec_o.op1   = rdata_a_i;
        dec_o.op2   = imm_i;
        // other immediate alu ops are not implemented.
        dec_o.rd_we = (funct3 == rv_pkg::F3_ADDI) || (funct3 == rv_pkg::F3_SLTI) ||
                      (funct3 == rv_pkg::F3_SLTIU);
      end
      rv_pkg::OPC_LB: begin
        dec_o.op1   = rdata_a_i;
        dec_o.op2   = imm_i;
        dec_o.rd_we = (funct3 == rv_pkg::F3_LB);  // byte loads only.
      end
      rv_pkg::OPC_JAL: begin
        dec_o.op1   = pc_plus4;           // link value.
        dec_o.op2   = pc_i + imm_j;       // target.
        dec_o.rd_we = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        dec_o.op1   = rdata_a_i;
        dec_o.op2   = imm_i;
        dec_o.t1    = pc_plus4;
        dec_o.rd_we = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        dec_o.op1 = rdata_a_i;
        dec_o.op2 = rdata_b_i;
        dec_o.t1  = pc_i + imm_b;         // taken target.
      end
      default: ;
    endcase
    if (rd == 5'd0) begin
      dec_o.rd_we = 1'b0;
    end
  end

endmodule

// File: rtl/regfile.sv
// integer register file: 31 writable 64-bit registers, x0 tied to zero.
`timescale 1ns/10ps

module regfile (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [4:0]              ra_i,
  input  logic [4:0]              rb_i,
  output logic [rv_pkg::XLEN-1:0] rdata_a_o,
  output logic [rv_pkg::XLEN-1:0] rdata_b_o,
  input  logic                    we_i,
  input  logic [4:0]              wa_i,
  input  logic [rv_pkg::XLEN-1:0] wdata_i
);

  logic [rv_pkg::XLEN-1:0] regs [1:31];  // no storage behind x0.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (wa_i != 5'd0)) begin
      regs[wa_i] <= wdata_i;
    end
  end

  // asynchronous reads, the write lands on the next edge.
  assign rdata_a_o = (ra_i == 5'd0) ? '0 : regs[ra_i];
  assign rdata_b_o = (rb_i == 5'd0) ? '0 : regs[rb_i];

endmodule

// File: rtl/rv_pkg.sv
// shared types: xlen, opcode and funct3 codes, stage structs, control states.
package rv_pkg;

  localparam int XLEN = 64;

  // defaults for the core parameters, overridden from the top level.
  localparam logic [XLEN-1:0] DEF_BOOT_ADDR = '0;
  localparam int              DEF_WB_AW     = 32;

  localparam logic [XLEN-1:0] PC_STEP = 4;  // one 32-bit instruction.

  // ----------------------------------------------------------
  // instruction encodings
  // ----------------------------------------------------------
  typedef enum logic [4:0] {
    OPC_LB     = 5'b00000,
    OPC_ADDI   = 5'b00100,
    OPC_AUIPC  = 5'b00101,
    OPC_BRANCH = 5'b11000,
    OPC_JALR   = 5'b11001,
    OPC_JAL    = 5'b11011
  } opcode_e;  // instruction bits 6:2.

  typedef logic [2:0] funct3_e;  // codes repeat between groups.

  localparam funct3_e F3_LB    = 3'b000;
  localparam funct3_e F3_ADDI  = 3'b000;
  localparam funct3_e F3_SLTI  = 3'b010;
  localparam funct3_e F3_SLTIU = 3'b011;
  localparam funct3_e F3_BEQ   = 3'b000;
  localparam funct3_e F3_BNE   = 3'b001;
  localparam funct3_e F3_BLT   = 3'b100;
  localparam funct3_e F3_BGE   = 3'b101;
  localparam funct3_e F3_BLTU  = 3'b110;
  localparam funct3_e F3_BGEU  = 3'b111;

  // ----------------------------------------------------------
  // stage payloads
  // ----------------------------------------------------------
  typedef struct packed {
    opcode_e         opcode;
    funct3_e         funct3;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] t1;
    logic [4:0]      rd;
    logic            rd_we;
  } dec_s;

  typedef struct packed {
    logic            rd_we;
    logic [4:0]      rd;
    logic [XLEN-1:0] rd_wdata;
    logic            jmp;
    logic [XLEN-1:0] jmp_addr;
    logic            ld;
    logic [XLEN-1:0] ld_addr;
  } exe_res_s;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic            rd_we;
    logic [4:0]      rd;
    logic [XLEN-1:0] rd_wdata;
  } commit_s;

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXECUTE,
    MEMORY,
    WRITEBACK
  } ctrl_state_e;

endpackage

// File: rtl/rvcore_top.sv
// core top level: control, decode, register file and execute.
`timescale 1ns/10ps

module rvcore_top #(
  parameter logic [rv_pkg::XLEN-1:0] BOOT_ADDR = rv_pkg::DEF_BOOT_ADDR,
  parameter int                      WB_AW     = rv_pkg::DEF_WB_AW
) (
  input  logic             clk,
  input  logic             rst,
  output logic             wb_cyc_o,
  output logic             wb_stb_o,
  output logic             wb_we_o,
  output logic [WB_AW-1:0] wb_adr_o,
  output logic [3:0]       wb_sel_o,
  input  logic [31:0]      wb_dat_i,
  input  logic             wb_ack_i,
  output logic             commit_valid_o,
  output rv_pkg::commit_s  commit_o
);

  logic [31:0]             inst;
  logic [rv_pkg::XLEN-1:0] pc;
  logic [4:0]              ra;
  logic [4:0]              rb;
  logic [rv_pkg::XLEN-1:0] rdata_a;
  logic [rv_pkg::XLEN-1:0] rdata_b;
  rv_pkg::dec_s            dec;
  rv_pkg::exe_res_s        res;
  logic                    rf_we;
  logic [4:0]              rf_wa;
  logic [rv_pkg::XLEN-1:0] rf_wdata;

  core_ctrl #(
    .BOOT_ADDR (BOOT_ADDR),
    .WB_AW     (WB_AW)
  ) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_we_o        (wb_we_o),
    .wb_adr_o       (wb_adr_o),
    .wb_sel_o       (wb_sel_o),
    .wb_dat_i       (wb_dat_i),
    .wb_ack_i       (wb_ack_i),
    .inst_o         (inst),
    .pc_o           (pc),
    .res_i          (res),
    .rf_we_o        (rf_we),
    .rf_wa_o        (rf_wa),
    .rf_wdata_o     (rf_wdata),
    .commit_valid_o (commit_valid_o),
    .commit_o       (commit_o)
  );

  id_stage u_id (
    .inst_i    (inst),
    .pc_i      (pc),
    .ra_o      (ra),
    .rb_o      (rb),
    .rdata_a_i (rdata_a),
    .rdata_b_i (rdata_b),
    .dec_o     (dec)
  );

  regfile u_rf (
    .clk       (clk),
    .rst       (rst),
    .ra_i      (ra),
    .rb_i      (rb),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (rf_we),
    .wa_i      (rf_wa),
    .wdata_i   (rf_wdata)
  );

  exe_stage u_exe (
    .dec_i (dec),
    .res_o (res)
  );

endmodule

// File: verif/rvcore_assert.sv
// concurrent checks on the wishbone master and the commit port, bound to the core top.
`timescale 1ns/10ps

module rvcore_assert #(
  parameter int AW = 32
) (
  input logic            clk_i,
  input logic            rst_i,
  input logic            cyc_i,
  input logic            stb_i,
  input logic            we_i,
  input logic [AW-1:0]   adr_i,
  input logic            ack_i,
  input logic            commit_valid_i,
  input rv_pkg::commit_s commit_i
);

  int fail_cnt = 0;  // failed assertions so far.

  a_stb_cyc: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
    else begin
      $error("stb high without cyc");
      fail_cnt++;
    end

  a_read_only: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> !we_i)
    else begin
      $error("write cycle on a read only port");
      fail_cnt++;
    end

  // request held with the same address until acknowledged.
  a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (stb_i && !ack_i) |=> (stb_i && $stable(adr_i)))
    else begin
      $error("request dropped or address changed before ack");
      fail_cnt++;
    end

  a_rst_idle: assert property (@(posedge clk_i)
    rst_i |=> (!cyc_i && !stb_i && !commit_valid_i))
    else begin
      $error("bus or commit active during reset");
      fail_cnt++;
    end

  a_commit_x0: assert property (@(posedge clk_i) disable iff (rst_i)
    commit_valid_i |-> !(commit_i.rd_we && (commit_i.rd == 5'd0)))
    else begin
      $error("commit writes x0");
      fail_cnt++;
    end

  a_commit_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    commit_valid_i |=> !commit_valid_i)
    else begin
      $error("commit valid longer than one cycle");
      fail_cnt++;
    end

endmodule

bind rvcore_top rvcore_assert #(.AW(WB_AW)) u_assert (
  .clk_i          (clk),
  .rst_i          (rst),
  .cyc_i          (wb_cyc_o),
  .stb_i          (wb_stb_o),
  .we_i           (wb_we_o),
  .adr_i          (wb_adr_o),
  .ack_i          (wb_ack_i),
  .commit_valid_i (commit_valid_o),
  .commit_i       (commit_o)
);

// File: verif/tb_mem.sv
// wishbone classic slave memory with random wait states, word array for program and data.
`timescale 1ns/10ps

module tb_mem #(
  parameter int          AW    = 32,
  parameter int          DEPTH = 256,
  parameter logic [31:0] SEED  = 32'h1
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          cyc_i,
  input  logic          stb_i,
  input  logic          we_i,
  input  logic [AW-1:0] adr_i,
  input  logic [3:0]    sel_i,
  output logic [31:0]   dat_o,
  output logic          ack_o
);

  localparam int IW = $clog2(DEPTH);

  logic [31:0] mem [0:DEPTH-1];

  // background content, every word differs with its address.
  task automatic fill_pattern();
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 32'hc0de_0000 ^ i;
    end
  endtask

  task automatic write_word(input logic [63:0] addr, input logic [31:0] data);
    mem[addr[IW+1:2]] = data;
  endtask

  task automatic write_byte(input logic [63:0] addr, input logic [7:0] data);
    mem[addr[IW+1:2]][8*addr[1:0] +: 8] = data;  // little endian lane.
  endtask

  // ----------------------------------------------------------
  // slave response, driven 1 ns after the edge
  // ----------------------------------------------------------
  initial begin
    int unsigned waits;
    logic [31:0] rdata;
    ack_o = 1'b0;
    dat_o = '0;
    waits = $urandom(SEED) % 4;
    forever begin
      @(posedge clk_i);
      if (rst_i) begin
        #1 ack_o = 1'b0;
      end else if (ack_o) begin
        #1 ack_o = 1'b0;
        waits = $urandom % 4;  // wait states for the next access.
      end else if (cyc_i && stb_i && !we_i) begin
        if (waits == 0) begin
          // lanes outside sel read as zero.
          rdata = mem[adr_i[IW+1:2]] &
                  {{8{sel_i[3]}}, {8{sel_i[2]}}, {8{sel_i[1]}}, {8{sel_i[0]}}};
          #1;
          dat_o = rdata;
          ack_o = 1'b1;
        end else begin
          waits--;
        end
      end
    end
  end

endmodule

// File: verif/tb_rvcore.sv
// testbench top: clock, reset, program and expected commit table, checker and timeout.
`timescale 1ns/10ps

module tb_rvcore;

  logic                    clk;
  logic                    rst;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [31:0]             wb_adr;
  logic [3:0]              wb_sel;
  logic [31:0]             wb_dat;
  logic                    wb_ack;
  logic                    commit_valid;
  rv_pkg::commit_s         commit;

  string                   name_q [$];
  logic [31:0]             inst_q [$];
  rv_pkg::commit_s         exp_q  [$];
  int                      chk_cnt;
  int                      err_cnt;
  int                      retired;
  int                      cycle_limit;

  rvcore_top #(
    .BOOT_ADDR (64'h0),
    .WB_AW     (32)
  ) DUT (
    .clk            (clk),
    .rst            (rst),
    .wb_cyc_o       (wb_cyc),
    .wb_stb_o       (wb_stb),
    .wb_we_o        (wb_we),
    .wb_adr_o       (wb_adr),
    .wb_sel_o       (wb_sel),
    .wb_dat_i       (wb_dat),
    .wb_ack_i       (wb_ack),
    .commit_valid_o (commit_valid),
    .commit_o       (commit)
  );

  tb_mem #(
    .AW   (32),
    .SEED (32'hbc84_61f7)
  ) u_mem (
    .clk_i (clk),
    .rst_i (rst),
    .cyc_i (wb_cyc),
    .stb_i (wb_stb),
    .we_i  (wb_we),
    .adr_i (wb_adr),
    .sel_i (wb_sel),
    .dat_o (wb_dat),
    .ack_o (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------
  // instruction encoders
  // ----------------------------------------------------------
  function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input rv_pkg::opcode_e opc);
    return {imm[11:0], rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] u_type(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[19:0], rd, rv_pkg::OPC_AUIPC, 2'b11};
  endfunction

  function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH, 2'b11};
  endfunction

  function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL, 2'b11};
  endfunction

  task automatic add_entry(input string name, input logic [63:0] addr, input logic [31:0] inst,
                           input logic we, input logic [4:0] rd, input logic [63:0] wdata);
    rv_pkg::commit_s exp;
    exp.pc       = addr;
    exp.rd_we    = we;
    exp.rd       = rd;
    exp.rd_wdata = wdata;
    name_q.push_back(name);
    inst_q.push_back(inst);
    exp_q.push_back(exp);
  endtask

  // ----------------------------------------------------------
  // result checks
  // ----------------------------------------------------------
  task automatic verify_wdata(input string name, input logic [rv_pkg::XLEN-1:0] exp,
                              input logic [rv_pkg::XLEN-1:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %s wdata expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_commit(input string name, input rv_pkg::commit_s exp,
                                input rv_pkg::commit_s act);
    chk_cnt++;
    if (act.pc !== exp.pc) begin
      err_cnt++;
      $display("ERR %s pc expected %h actual %h", name, exp.pc, act.pc);
    end
    if (act.rd_we !== exp.rd_we) begin
      err_cnt++;
      $display("ERR %s rd_we expected %b actual %b", name, exp.rd_we, act.rd_we);
    end
    if (exp.rd_we) begin  // register fields only matter on a write.
      if (act.rd !== exp.rd) begin
        err_cnt++;
        $display("ERR %s rd expected %0d actual %0d", name, exp.rd, act.rd);
      end
      verify_wdata(name, exp.rd_wdata, act.rd_wdata);
    end
  endtask

  task automatic report_counts();
    $display("checks: %0d, errors: %0d, assertion failures: %0d, retired: %0d",
             chk_cnt, err_cnt, DUT.u_assert.fail_cnt, retired);
  endtask

  // ----------------------------------------------------------
  // program table and checker
  // ----------------------------------------------------------
  initial begin
    rst     = 1'b1;
    chk_cnt = 0;
    err_cnt = 0;
    retired = 0;
    // name, pc, instruction, rd_we, rd, write data.
    add_entry("addi_imm",      64'h00, i_type(5, 0, rv_pkg::F3_ADDI, 1, rv_pkg::OPC_ADDI),
              1, 1, 64'd5);
    add_entry("addi_chain",    64'h04, i_type(7, 1, rv_pkg::F3_ADDI, 1, rv_pkg::OPC_ADDI),
              1, 1, 64'd12);
    add_entry("addi_neg",      64'h08, i_type(-3, 0, rv_pkg::F3_ADDI, 2, rv_pkg::OPC_ADDI),
              1, 2, 64'hffff_ffff_ffff_fffd);
    add_entry("slti_neg_rs",   64'h0c, i_type(1, 2, rv_pkg::F3_SLTI, 3, rv_pkg::OPC_ADDI),
              1, 3, 64'd1);
    add_entry("sltiu_neg_rs",  64'h10, i_type(1, 2, rv_pkg::F3_SLTIU, 4, rv_pkg::OPC_ADDI),
              1, 4, 64'd0);
    add_entry("slti_neg_imm",  64'h14, i_type(-1, 1, rv_pkg::F3_SLTI, 5, rv_pkg::OPC_ADDI),
              1, 5, 64'd0);
    add_entry("sltiu_neg_imm", 64'h18, i_type(-1, 1, rv_pkg::F3_SLTIU, 6, rv_pkg::OPC_ADDI),
              1, 6, 64'd1);
    add_entry("auipc_pos",     64'h1c, u_type(32'h12345, 7), 1, 7, 64'h1234_501c);
    add_entry("auipc_neg",     64'h20, u_type(32'h80000, 8), 1, 8, 64'hffff_ffff_8000_0020);
    add_entry("addi_x0",       64'h24, i_type(9, 1, rv_pkg::F3_ADDI, 0, rv_pkg::OPC_ADDI),
              0, 0, 64'd0);
    add_entry("jal_fwd",       64'h28, j_type(16, 9), 1, 9, 64'h2c);
    add_entry("addi_base",     64'h38, i_type(32'h41, 0, rv_pkg::F3_ADDI, 10, rv_pkg::OPC_ADDI),
              1, 10, 64'h41);
    add_entry("jalr_odd",      64'h3c, i_type(16, 10, 3'b000, 11, rv_pkg::OPC_JALR),
              1, 11, 64'h40);
    // x1 = 12, x2 = -3, x3 = x6 = 1; taken branches skip one word.
    add_entry("beq_taken",  64'h50, b_type(8, 6, 3, rv_pkg::F3_BEQ),  0, 0, 0);
    add_entry("beq_not",    64'h58, b_type(8, 3, 1, rv_pkg::F3_BEQ),  0, 0, 0);
    add_entry("bne_taken",  64'h5c, b_type(8, 3, 1, rv_pkg::F3_BNE),  0, 0, 0);
    add_entry("bne_not",    64'h64, b_type(8, 6, 3, rv_pkg::F3_BNE),  0, 0, 0);
    add_entry("blt_taken",  64'h68, b_type(8, 1, 2, rv_pkg::F3_BLT),  0, 0, 0);
    add_entry("bltu_not",   64'h70, b_type(8, 1, 2, rv_pkg::F3_BLTU), 0, 0, 0);
    add_entry("bltu_taken", 64'h74, b_type(8, 2, 1, rv_pkg::F3_BLTU), 0, 0, 0);
    add_entry("blt_not",    64'h7c, b_type(8, 2, 1, rv_pkg::F3_BLT),  0, 0, 0);
    add_entry("bge_taken",  64'h80, b_type(8, 2, 1, rv_pkg::F3_BGE),  0, 0, 0);
    add_entry("bge_not",    64'h88, b_type(8, 1, 2, rv_pkg::F3_BGE),  0, 0, 0);
    add_entry("bgeu_taken", 64'h8c, b_type(8, 1, 2, rv_pkg::F3_BGEU), 0, 0, 0);
    add_entry("bgeu_not",   64'h94, b_type(8, 2, 1, rv_pkg::F3_BGEU), 0, 0, 0);
    add_entry("addi_ptr",    64'h98, i_type(32'h200, 0, rv_pkg::F3_ADDI, 12, rv_pkg::OPC_ADDI),
              1, 12, 64'h200);
    add_entry("lb_lane0",    64'h9c, i_type(0, 12, rv_pkg::F3_LB, 13, rv_pkg::OPC_LB),
              1, 13, 64'h7f);
    add_entry("lb_lane1",    64'ha0, i_type(1, 12, rv_pkg::F3_LB, 14, rv_pkg::OPC_LB),
              1, 14, 64'hffff_ffff_ffff_ff80);
    add_entry("lb_lane2",    64'ha4, i_type(2, 12, rv_pkg::F3_LB, 15, rv_pkg::OPC_LB),
              1, 15, 64'h35);
    add_entry("addi_ptr4",   64'ha8, i_type(4, 12, rv_pkg::F3_ADDI, 17, rv_pkg::OPC_ADDI),
              1, 17, 64'h204);
    add_entry("lb_lane3",    64'hac, i_type(-1, 17, rv_pkg::F3_LB, 16, rv_pkg::OPC_LB),
              1, 16, 64'hffff_ffff_ffff_ffc4);
    add_entry("addi_use_ld", 64'hb0, i_type(32'h44, 16, rv_pkg::F3_ADDI, 18, rv_pkg::OPC_ADDI),
              1, 18, 64'h8);

    cycle_limit = exp_q.size() * 12 + 40;
    u_mem.fill_pattern();
    for (int n = 0; n < exp_q.size(); n++) begin
      u_mem.write_word(exp_q[n].pc, inst_q[n]);
    end
    u_mem.write_byte(64'h200, 8'h7f);  // load data, one byte per lane.
    u_mem.write_byte(64'h201, 8'h80);
    u_mem.write_byte(64'h202, 8'h35);
    u_mem.write_byte(64'h203, 8'hc4);

    repeat (16) @(posedge clk);
    #1 rst = 1'b0;

    for (int n = 0; n < exp_q.size(); n++) begin
      do begin
        @(negedge clk);
      end while (commit_valid !== 1'b1);
      compare_commit(name_q[n], exp_q[n], commit);
      retired++;
    end

    report_counts();
    if ((err_cnt == 0) && (DUT.u_assert.fail_cnt == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // ----------------------------------------------------------
  // timeout
  // ----------------------------------------------------------
  initial begin
    int cycles;
    cycles = 0;
    @(negedge rst);
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= cycle_limit) begin
        err_cnt++;
        $display("core stopped committing: %0d of %0d instructions retired in %0d cycles",
                 retired, exp_q.size(), cycles);
        report_counts();
        $display("** FAIL **");
        $finish;
      end
    end
  end

endmodule
